// ==== hw/l2_cache_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// L2 cache shared definitions
// Request opcodes, memory interface states and cache geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package l2_cache_pkg;

	// Request opcodes from the cores
	typedef enum logic [1:0]
	{
		LOAD,
		STORE,
		LOAD_SYNC,
		STORE_SYNC
	} l2_op_t;

	// System memory interface FSM
	typedef enum logic [2:0]
	{
		IDLE,
		WB_REQ,
		WB_RELEASE,
		FILL_REQ,
		FILL_RELEASE
	} smi_state_t;

	// Line of 16 bytes, one mask bit per byte
	localparam int LINE_BYTES = 16;
	localparam int LINE_BITS = LINE_BYTES * 8;

	// Two ways, so the way field is a single bit
	localparam int NUM_WAYS = 2;
	localparam int WAY_WIDTH = 1;

	// Line address width, tag plus set index
	localparam int ADDR_WIDTH = 12;

endpackage

// ==== hw/l2_cache_tag.sv ====
`timescale 1ns/1ns
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// L2 cache tag stage
// Registers the request, looks up tag, valid and dirty bits,
// picks the fill way and keeps one LRU bit per set
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module l2_cache_tag import l2_cache_pkg::*; #(
	parameter int NUM_CORES = 4,
	parameter int NUM_STRANDS = 4,
	parameter int SET_INDEX_WIDTH = 3
) (
	input logic clk,
	input logic reset,
	input logic stall,
	input logic l2req_valid,
	input logic [$clog2(NUM_CORES)-1:0] l2req_core,
	input logic [$clog2(NUM_STRANDS)-1:0] l2req_strand,
	input l2_op_t l2req_op,
	input logic [ADDR_WIDTH-1:0] l2req_address,
	input logic [LINE_BITS-1:0] l2req_data,
	input logic [LINE_BYTES-1:0] l2req_mask,
	input logic wr_update_enable,
	input logic [WAY_WIDTH+SET_INDEX_WIDTH-1:0] wr_cache_write_index,
	input logic wr_set_dirty,
	output logic tg_valid,
	output logic [$clog2(NUM_CORES)-1:0] tg_core,
	output logic [$clog2(NUM_STRANDS)-1:0] tg_strand,
	output l2_op_t tg_op,
	output logic [ADDR_WIDTH-1:0] tg_address,
	output logic [LINE_BITS-1:0] tg_data,
	output logic [LINE_BYTES-1:0] tg_mask,
	output logic tg_hit,
	output logic [WAY_WIDTH-1:0] tg_hit_way,
	output logic [WAY_WIDTH-1:0] tg_fill_way,
	output logic tg_victim_dirty,
	output logic [ADDR_WIDTH-SET_INDEX_WIDTH-1:0] tg_victim_tag
);
	localparam int TAG_WIDTH = ADDR_WIDTH - SET_INDEX_WIDTH;
	localparam int NUM_SETS = 1 << SET_INDEX_WIDTH;

	logic [TAG_WIDTH-1:0] tag_mem [NUM_WAYS][NUM_SETS];
	logic [NUM_WAYS-1:0] valid_mem [NUM_SETS];
	logic [NUM_WAYS-1:0] dirty_mem [NUM_SETS];
	logic [NUM_SETS-1:0] lru;
	// Tag of the request now in the read stage, written on its update
	logic [TAG_WIDTH-1:0] pending_tag;
	logic [SET_INDEX_WIDTH-1:0] set_index;
	logic [TAG_WIDTH-1:0] req_tag;
	logic [WAY_WIDTH-1:0] wr_way;
	logic [SET_INDEX_WIDTH-1:0] wr_set;
	logic [NUM_WAYS-1:0] way_valid;
	logic [NUM_WAYS-1:0] way_dirty;
	logic [NUM_WAYS-1:0] hit_vec;
	logic [TAG_WIDTH-1:0] way_tag [NUM_WAYS];

	assign set_index = tg_address[SET_INDEX_WIDTH-1:0];
	assign req_tag = tg_address[ADDR_WIDTH-1:SET_INDEX_WIDTH];
	assign wr_way = wr_cache_write_index[SET_INDEX_WIDTH +: WAY_WIDTH];
	assign wr_set = wr_cache_write_index[SET_INDEX_WIDTH-1:0];

	// Lookup of the held request, bypassing this cycle's update
	// so a line filled right now already counts as present
	always_comb
	begin
		for (int w = 0; w < NUM_WAYS; w++)
		begin
			if (wr_update_enable && wr_way == WAY_WIDTH'(w) && wr_set == set_index)
			begin
				way_valid[w] = 1'b1;
				way_dirty[w] = wr_set_dirty;
				way_tag[w] = pending_tag;
			end
			else
			begin
				way_valid[w] = valid_mem[set_index][w];
				way_dirty[w] = dirty_mem[set_index][w];
				way_tag[w] = tag_mem[w][set_index];
			end
			hit_vec[w] = way_valid[w] && way_tag[w] == req_tag;
		end
	end

	assign tg_hit = |hit_vec;
	assign tg_hit_way = hit_vec[1];

	// Empty way first, otherwise the least recently used one
	always_comb
	begin
		if (!way_valid[0])
			tg_fill_way = 1'b0;
		else if (!way_valid[1])
			tg_fill_way = 1'b1;
		else
			tg_fill_way = lru[set_index];
	end

	assign tg_victim_dirty = way_valid[tg_fill_way] && way_dirty[tg_fill_way];
	assign tg_victim_tag = way_tag[tg_fill_way];

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			tg_valid <= 1'b0;
		else if (!stall)
			tg_valid <= l2req_valid;
	end

	always_ff @(posedge clk)
	begin
		if (!stall)
		begin
			tg_core <= l2req_core;
			tg_strand <= l2req_strand;
			tg_op <= l2req_op;
			tg_address <= l2req_address;
			tg_data <= l2req_data;
			tg_mask <= l2req_mask;
			pending_tag <= req_tag;
		end
		if (wr_update_enable)
			tag_mem[wr_way][wr_set] <= pending_tag;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int s = 0; s < NUM_SETS; s++)
			begin
				valid_mem[s] <= '0;
				dirty_mem[s] <= '0;
			end
			lru <= '0;
		end
		else
		begin
			if (wr_update_enable)
			begin
				valid_mem[wr_set][wr_way] <= 1'b1;
				dirty_mem[wr_set][wr_way] <= wr_set_dirty;
			end
			// LRU now points at the way not used by this access
			if (tg_valid && !stall)
				lru[set_index] <= !(tg_hit ? tg_hit_way : tg_fill_way);
		end
	end

	// A line is never present in both ways of a set
	one_way_hit: assert property (@(posedge clk) disable iff (reset)
		tg_valid |-> !(hit_vec[0] && hit_vec[1]));

endmodule

// ==== hw/l2_cache_read.sv ====
`timescale 1ns/1ns
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// L2 cache read stage
// Reads both ways of the line data array, keeps the
// per-strand sync links and holds the fill data on a miss
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module l2_cache_read import l2_cache_pkg::*; #(
	parameter int NUM_CORES = 4,
	parameter int NUM_STRANDS = 4,
	parameter int SET_INDEX_WIDTH = 3
) (
	input logic clk,
	input logic reset,
	input logic stall,
	input logic tg_valid,
	input logic [$clog2(NUM_CORES)-1:0] tg_core,
	input logic [$clog2(NUM_STRANDS)-1:0] tg_strand,
	input l2_op_t tg_op,
	input logic [ADDR_WIDTH-1:0] tg_address,
	input logic [LINE_BITS-1:0] tg_data,
	input logic [LINE_BYTES-1:0] tg_mask,
	input logic tg_hit,
	input logic [WAY_WIDTH-1:0] tg_hit_way,
	input logic [WAY_WIDTH-1:0] tg_fill_way,
	input logic tg_victim_dirty,
	input logic [ADDR_WIDTH-SET_INDEX_WIDTH-1:0] tg_victim_tag,
	input logic smi_fill_valid,
	input logic [LINE_BITS-1:0] smi_fill_data,
	input logic wr_update_enable,
	input logic [WAY_WIDTH+SET_INDEX_WIDTH-1:0] wr_cache_write_index,
	input logic [LINE_BITS-1:0] wr_update_data,
	output logic rd_valid,
	output logic [$clog2(NUM_CORES)-1:0] rd_core,
	output logic [$clog2(NUM_STRANDS)-1:0] rd_strand,
	output l2_op_t rd_op,
	output logic [ADDR_WIDTH-1:0] rd_address,
	output logic [LINE_BITS-1:0] rd_data,
	output logic [LINE_BYTES-1:0] rd_mask,
	output logic rd_cache_hit,
	output logic [WAY_WIDTH-1:0] rd_hit_way,
	output logic [WAY_WIDTH-1:0] rd_fill_way,
	output logic rd_has_sm_data,
	output logic [LINE_BITS-1:0] rd_sm_data,
	output logic [LINE_BITS-1:0] rd_cache_mem_result,
	output logic rd_store_sync_success,
	output logic rd_miss,
	output logic rd_victim_dirty,
	output logic [ADDR_WIDTH-1:0] rd_victim_address,
	output logic [LINE_BITS-1:0] rd_victim_line
);
	localparam int NUM_SETS = 1 << SET_INDEX_WIDTH;
	localparam int LINK_ID_WIDTH = $clog2(NUM_CORES) + $clog2(NUM_STRANDS);
	localparam int NUM_LINKS = 1 << LINK_ID_WIDTH;

	logic [LINE_BITS-1:0] data_mem [NUM_WAYS][NUM_SETS];
	logic [LINE_BITS-1:0] way_line [NUM_WAYS];
	logic [NUM_LINKS-1:0] link_valid;
	logic [ADDR_WIDTH-1:0] link_address [NUM_LINKS];
	logic [LINK_ID_WIDTH-1:0] link_id;
	logic [SET_INDEX_WIDTH-1:0] set_index;
	logic [WAY_WIDTH-1:0] wr_way;
	logic [SET_INDEX_WIDTH-1:0] wr_set;
	logic line_written;

	assign set_index = tg_address[SET_INDEX_WIDTH-1:0];
	assign wr_way = wr_cache_write_index[SET_INDEX_WIDTH +: WAY_WIDTH];
	assign wr_set = wr_cache_write_index[SET_INDEX_WIDTH-1:0];

	// Data array, both ways read into registers
	// Same-cycle write to the same set and way is forwarded
	always_ff @(posedge clk)
	begin
		if (wr_update_enable)
			data_mem[wr_way][wr_set] <= wr_update_data;
		if (!stall)
		begin
			for (int w = 0; w < NUM_WAYS; w++)
			begin
				if (wr_update_enable && wr_way == WAY_WIDTH'(w) && wr_set == set_index)
					way_line[w] <= wr_update_data;
				else
					way_line[w] <= data_mem[w][set_index];
			end
		end
	end

	assign rd_cache_mem_result = way_line[rd_hit_way];
	assign rd_victim_line = way_line[rd_fill_way];

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			rd_valid <= 1'b0;
			rd_has_sm_data <= 1'b0;
		end
		else if (!stall)
		begin
			rd_valid <= tg_valid;
			rd_has_sm_data <= 1'b0;
		end
		else if (smi_fill_valid)
			rd_has_sm_data <= 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (!stall)
		begin
			rd_core <= tg_core;
			rd_strand <= tg_strand;
			rd_op <= tg_op;
			rd_address <= tg_address;
			rd_data <= tg_data;
			rd_mask <= tg_mask;
			rd_cache_hit <= tg_hit;
			rd_hit_way <= tg_hit_way;
			rd_fill_way <= tg_fill_way;
			rd_victim_dirty <= tg_victim_dirty;
			rd_victim_address <= {tg_victim_tag, set_index};
		end
		// Fill line from memory, held until the request moves on
		if (stall && smi_fill_valid)
			rd_sm_data <= smi_fill_data;
	end

	assign rd_miss = rd_valid && !rd_cache_hit && !rd_has_sm_data;

	// Sync links, one per core and strand
	assign link_id = {rd_core, rd_strand};
	assign rd_store_sync_success = link_valid[link_id] && link_address[link_id] == rd_address;
	assign line_written = rd_op == STORE || (rd_op == STORE_SYNC && rd_store_sync_success);

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			link_valid <= '0;
		else if (rd_valid && !stall)
		begin
			// Any write to the line breaks every link on it
			if (line_written)
			begin
				for (int l = 0; l < NUM_LINKS; l++)
					if (link_address[l] == rd_address)
						link_valid[l] <= 1'b0;
			end
			if (rd_op == LOAD_SYNC)
				link_valid[link_id] <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rd_valid && !stall && rd_op == LOAD_SYNC)
			link_address[link_id] <= rd_address;
	end

	// Once the fill is in, the memory side has let go of the pipeline
	fill_leaves: assert property (@(posedge clk) disable iff (reset)
		rd_has_sm_data |-> !stall);

endmodule

// ==== hw/l2_cache_write.sv ====
`timescale 1ns/1ns
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// L2 cache write stage
// Merges store bytes into the line, drives the array update
// and registers the response
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module l2_cache_write import l2_cache_pkg::*; #(
	parameter int NUM_CORES = 4,
	parameter int NUM_STRANDS = 4,
	parameter int SET_INDEX_WIDTH = 3
) (
	input logic clk,
	input logic reset,
	input logic stall,
	input logic rd_valid,
	input logic [$clog2(NUM_CORES)-1:0] rd_core,
	input logic [$clog2(NUM_STRANDS)-1:0] rd_strand,
	input l2_op_t rd_op,
	input logic [ADDR_WIDTH-1:0] rd_address,
	input logic [LINE_BITS-1:0] rd_data,
	input logic [LINE_BYTES-1:0] rd_mask,
	input logic rd_cache_hit,
	input logic [WAY_WIDTH-1:0] rd_hit_way,
	input logic [WAY_WIDTH-1:0] rd_fill_way,
	input logic rd_has_sm_data,
	input logic [LINE_BITS-1:0] rd_sm_data,
	input logic [LINE_BITS-1:0] rd_cache_mem_result,
	input logic rd_store_sync_success,
	output logic wr_update_enable,
	output logic [WAY_WIDTH+SET_INDEX_WIDTH-1:0] wr_cache_write_index,
	output logic [LINE_BITS-1:0] wr_update_data,
	output logic wr_set_dirty,
	output logic resp_valid,
	output logic [$clog2(NUM_CORES)-1:0] resp_core,
	output logic [$clog2(NUM_STRANDS)-1:0] resp_strand,
	output l2_op_t resp_op,
	output logic [LINE_BITS-1:0] resp_data,
	output logic resp_sync_success
);
	logic [LINE_BITS-1:0] old_line;
	logic [LINE_BITS-1:0] merged_line;
	logic is_store;
	logic store_commits;

	// Fill data wins over the array copy
	assign old_line = rd_has_sm_data ? rd_sm_data : rd_cache_mem_result;

	// Byte-masked merge
	always_comb
	begin
		for (int b = 0; b < LINE_BYTES; b++)
			merged_line[b*8 +: 8] = rd_mask[b] ? rd_data[b*8 +: 8] : old_line[b*8 +: 8];
	end

	assign is_store = rd_op == STORE || rd_op == STORE_SYNC;
	assign store_commits = rd_op == STORE || (rd_op == STORE_SYNC && rd_store_sync_success);

	always_comb
	begin
		wr_update_enable = 1'b0;
		wr_update_data = rd_sm_data;
		wr_set_dirty = 1'b0;
		if (rd_valid && !stall)
		begin
			if (store_commits && (rd_cache_hit || rd_has_sm_data))
			begin
				// Store hit or store after fill, line becomes dirty
				wr_update_enable = 1'b1;
				wr_update_data = merged_line;
				wr_set_dirty = 1'b1;
			end
			else if (rd_has_sm_data)
			begin
				// Load fill, or failed store-sync after fill
				// The tag is already claimed, so the clean line still goes in
				wr_update_enable = 1'b1;
			end
		end
	end

	// Hit way on a hit, fill way otherwise
	assign wr_cache_write_index = {rd_cache_hit ? rd_hit_way : rd_fill_way,
		rd_address[SET_INDEX_WIDTH-1:0]};

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			resp_valid <= 1'b0;
		else
			resp_valid <= rd_valid && !stall;
	end

	always_ff @(posedge clk)
	begin
		if (!stall)
		begin
			resp_core <= rd_core;
			resp_strand <= rd_strand;
			resp_op <= rd_op;
			// Merged line for any store, even a failing store-sync
			resp_data <= is_store ? merged_line : old_line;
			resp_sync_success <= rd_op == STORE_SYNC && rd_store_sync_success;
		end
	end

endmodule

// ==== hw/l2_cache_smi.sv ====
`timescale 1ns/1ns
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// L2 cache system memory interface
// Writes back a dirty victim, then fetches the missed line
// over a four-phase req/ack handshake
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module l2_cache_smi import l2_cache_pkg::*; (
	input logic clk,
	input logic reset,
	input logic rd_miss,
	input logic [ADDR_WIDTH-1:0] rd_address,
	input logic rd_victim_dirty,
	input logic [ADDR_WIDTH-1:0] rd_victim_address,
	input logic [LINE_BITS-1:0] rd_victim_line,
	output logic stall,
	output logic smi_fill_valid,
	output logic [LINE_BITS-1:0] smi_fill_data,
	output logic mem_req,
	output logic mem_write,
	output logic [ADDR_WIDTH-1:0] mem_address,
	output logic [LINE_BITS-1:0] mem_write_data,
	input logic mem_ack,
	input logic [LINE_BITS-1:0] mem_read_data
);
	smi_state_t state;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state <= IDLE;
			smi_fill_valid <= 1'b0;
		end
		else
		begin
			smi_fill_valid <= 1'b0;
			case (state)
				IDLE:
				begin
					// Fill pulse cycle still shows the old miss, skip it
					if (rd_miss && !smi_fill_valid && !mem_ack)
						state <= rd_victim_dirty ? WB_REQ : FILL_REQ;
				end
				WB_REQ:
					if (mem_ack)
						state <= WB_RELEASE;
				WB_RELEASE:
					if (!mem_ack)
						state <= FILL_REQ;
				FILL_REQ:
					if (mem_ack)
						state <= FILL_RELEASE;
				FILL_RELEASE:
				begin
					if (!mem_ack)
					begin
						state <= IDLE;
						smi_fill_valid <= 1'b1;
					end
				end
				default:
					state <= IDLE;
			endcase
		end
	end

	// Read data is only valid while ack is high
	always_ff @(posedge clk)
	begin
		if (state == FILL_REQ && mem_ack)
			smi_fill_data <= mem_read_data;
	end

	// Request fields come straight from the held read stage
	assign mem_req = state == WB_REQ || state == FILL_REQ;
	assign mem_write = state == WB_REQ;
	assign mem_address = mem_write ? rd_victim_address : rd_address;
	assign mem_write_data = rd_victim_line;

	// Held from the first miss cycle until the fill has been latched
	assign stall = rd_miss || state != IDLE;

	// A new request waits for the previous ack to drop
	req_after_ack: assert property (@(posedge clk) disable iff (reset)
		(!mem_req && mem_ack) |=> !mem_req);

endmodule

// ==== hw/l2_cache.sv ====
`timescale 1ns/1ns
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// L2 cache top level
// Tag, read and write stages plus the memory interface
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module l2_cache import l2_cache_pkg::*; #(
	parameter int NUM_CORES = 4,
	parameter int NUM_STRANDS = 4,
	parameter int SET_INDEX_WIDTH = 3
) (
	input logic clk,
	input logic reset,
	input logic l2req_valid,
	input logic [$clog2(NUM_CORES)-1:0] l2req_core,
	input logic [$clog2(NUM_STRANDS)-1:0] l2req_strand,
	input l2_op_t l2req_op,
	input logic [ADDR_WIDTH-1:0] l2req_address,
	input logic [LINE_BITS-1:0] l2req_data,
	input logic [LINE_BYTES-1:0] l2req_mask,
	output logic stall,
	output logic resp_valid,
	output logic [$clog2(NUM_CORES)-1:0] resp_core,
	output logic [$clog2(NUM_STRANDS)-1:0] resp_strand,
	output l2_op_t resp_op,
	output logic [LINE_BITS-1:0] resp_data,
	output logic resp_sync_success,
	output logic mem_req,
	output logic mem_write,
	output logic [ADDR_WIDTH-1:0] mem_address,
	output logic [LINE_BITS-1:0] mem_write_data,
	input logic mem_ack,
	input logic [LINE_BITS-1:0] mem_read_data
);
	// Tag stage to read stage
	logic tg_valid;
	logic [$clog2(NUM_CORES)-1:0] tg_core;
	logic [$clog2(NUM_STRANDS)-1:0] tg_strand;
	l2_op_t tg_op;
	logic [ADDR_WIDTH-1:0] tg_address;
	logic [LINE_BITS-1:0] tg_data;
	logic [LINE_BYTES-1:0] tg_mask;
	logic tg_hit;
	logic [WAY_WIDTH-1:0] tg_hit_way;
	logic [WAY_WIDTH-1:0] tg_fill_way;
	logic tg_victim_dirty;
	logic [ADDR_WIDTH-SET_INDEX_WIDTH-1:0] tg_victim_tag;

	// Read stage to write stage and memory interface
	logic rd_valid;
	logic [$clog2(NUM_CORES)-1:0] rd_core;
	logic [$clog2(NUM_STRANDS)-1:0] rd_strand;
	l2_op_t rd_op;
	logic [ADDR_WIDTH-1:0] rd_address;
	logic [LINE_BITS-1:0] rd_data;
	logic [LINE_BYTES-1:0] rd_mask;
	logic rd_cache_hit;
	logic [WAY_WIDTH-1:0] rd_hit_way;
	logic [WAY_WIDTH-1:0] rd_fill_way;
	logic rd_has_sm_data;
	logic [LINE_BITS-1:0] rd_sm_data;
	logic [LINE_BITS-1:0] rd_cache_mem_result;
	logic rd_store_sync_success;
	logic rd_miss;
	logic rd_victim_dirty;
	logic [ADDR_WIDTH-1:0] rd_victim_address;
	logic [LINE_BITS-1:0] rd_victim_line;

	// Write stage update, back to tag and read stages
	logic wr_update_enable;
	logic [WAY_WIDTH+SET_INDEX_WIDTH-1:0] wr_cache_write_index;
	logic [LINE_BITS-1:0] wr_update_data;
	logic wr_set_dirty;

	// Fill from memory
	logic smi_fill_valid;
	logic [LINE_BITS-1:0] smi_fill_data;

	l2_cache_tag #(
		.NUM_CORES(NUM_CORES),
		.NUM_STRANDS(NUM_STRANDS),
		.SET_INDEX_WIDTH(SET_INDEX_WIDTH)
	) tag_i (.*);

	l2_cache_read #(
		.NUM_CORES(NUM_CORES),
		.NUM_STRANDS(NUM_STRANDS),
		.SET_INDEX_WIDTH(SET_INDEX_WIDTH)
	) read_i (.*);

	l2_cache_write #(
		.NUM_CORES(NUM_CORES),
		.NUM_STRANDS(NUM_STRANDS),
		.SET_INDEX_WIDTH(SET_INDEX_WIDTH)
	) write_i (.*);

	l2_cache_smi smi_i (.*);

endmodule

// ==== bench/line_pattern.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Initial memory line content
// Fixed pattern built from the whole line address
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

function automatic logic [LINE_BITS-1:0] line_init(input logic [ADDR_WIDTH-1:0] addr);
	logic [LINE_BITS-1:0] line;
	// Word number, address, inverted low nibble, address again
	for (int w = 0; w < LINE_BITS / 32; w++)
		line[w*32 +: 32] = {4'(w), addr, ~addr[3:0], addr};
	return line;
endfunction

// ==== bench/l2_cache_checker.sv ====
`timescale 1ns/1ns
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// L2 cache response checker
// Reference line store and sync links, in-order compare
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module l2_cache_checker import l2_cache_pkg::*; #(
	parameter int NUM_CORES = 4,
	parameter int NUM_STRANDS = 4
) (
	input logic clk,
	input logic reset,
	input logic l2req_valid,
	input logic [$clog2(NUM_CORES)-1:0] l2req_core,
	input logic [$clog2(NUM_STRANDS)-1:0] l2req_strand,
	input l2_op_t l2req_op,
	input logic [ADDR_WIDTH-1:0] l2req_address,
	input logic [LINE_BITS-1:0] l2req_data,
	input logic [LINE_BYTES-1:0] l2req_mask,
	input logic stall,
	input logic [1:0] exp_sync,
	input logic [1:0] exp_reads,
	input logic [1:0] exp_writes,
	input logic resp_valid,
	input logic [$clog2(NUM_CORES)-1:0] resp_core,
	input logic [$clog2(NUM_STRANDS)-1:0] resp_strand,
	input l2_op_t resp_op,
	input logic [LINE_BITS-1:0] resp_data,
	input logic resp_sync_success,
	input logic mem_req,
	input logic mem_write,
	input logic mem_ack,
	output int error_count,
	output int resp_count
);
	localparam int NUM_LINKS = NUM_CORES * NUM_STRANDS;
	// Table value meaning no expectation
	localparam logic [1:0] DC = 2'd2;

	typedef struct packed {
		logic [$clog2(NUM_CORES)-1:0] core;
		logic [$clog2(NUM_STRANDS)-1:0] strand;
		l2_op_t op;
		logic [LINE_BITS-1:0] data;
		logic sync;
		logic [1:0] exp_sync;
		logic [1:0] exp_reads;
		logic [1:0] exp_writes;
	} expect_t;

	// Expected responses, oldest first
	expect_t pending[$];
	logic [LINE_BITS-1:0] lines [1 << ADDR_WIDTH];
	logic link_valid [NUM_LINKS];
	logic [ADDR_WIDTH-1:0] link_address [NUM_LINKS];
	// Memory transfers seen since the last response
	int reads_seen;
	int writes_seen;
	logic mem_req_q;

	`include "line_pattern.svh"

	function automatic logic [LINE_BITS-1:0] merge_bytes(input logic [LINE_BITS-1:0] old,
		input logic [LINE_BITS-1:0] data, input logic [LINE_BYTES-1:0] mask);
		logic [LINE_BITS-1:0] line;
		line = old;
		for (int b = 0; b < LINE_BYTES; b++)
			if (mask[b])
				line[b*8 +: 8] = data[b*8 +: 8];
		return line;
	endfunction

	task automatic mismatch(input string name, input logic [LINE_BITS-1:0] expected,
		input logic [LINE_BITS-1:0] actual);
		error_count++;
		$display("Mismatch at %0t ns: %s expected %h actual %h", $time, name, expected, actual);
	endtask

	task automatic fault(input string what);
		error_count++;
		$display("Error at %0t ns: %s", $time, what);
	endtask

	// Apply one accepted request to the model, in request order
	task automatic model_request();
		int id;
		logic [LINE_BITS-1:0] old;
		logic [LINE_BITS-1:0] merged;
		logic ok;
		expect_t e;
		id = l2req_core * NUM_STRANDS + l2req_strand;
		old = lines[l2req_address];
		merged = merge_bytes(old, l2req_data, l2req_mask);
		ok = l2req_op == STORE_SYNC && link_valid[id] && link_address[id] == l2req_address;
		// Any committed write kills every link on the line
		if (l2req_op == STORE || ok)
		begin
			lines[l2req_address] = merged;
			for (int l = 0; l < NUM_LINKS; l++)
				if (link_address[l] == l2req_address)
					link_valid[l] = 1'b0;
		end
		if (l2req_op == LOAD_SYNC)
		begin
			link_valid[id] = 1'b1;
			link_address[id] = l2req_address;
		end
		e.core = l2req_core;
		e.strand = l2req_strand;
		e.op = l2req_op;
		e.data = (l2req_op == STORE || l2req_op == STORE_SYNC) ? merged : old;
		e.sync = ok;
		e.exp_sync = exp_sync;
		e.exp_reads = exp_reads;
		e.exp_writes = exp_writes;
		pending.push_back(e);
	endtask

	task automatic check_response();
		expect_t e;
		if (pending.size() == 0)
		begin
			fault("response arrived with no request outstanding");
			return;
		end
		e = pending.pop_front();
		resp_count++;
		if (resp_core !== e.core)
			mismatch("resp_core", e.core, resp_core);
		if (resp_strand !== e.strand)
			mismatch("resp_strand", e.strand, resp_strand);
		if (resp_op !== e.op)
			mismatch("resp_op", e.op, resp_op);
		if (resp_data !== e.data)
			mismatch("resp_data", e.data, resp_data);
		if (resp_sync_success !== e.sync)
			mismatch("resp_sync_success", e.sync, resp_sync_success);
		// Table expectations for directed rows
		if (e.exp_sync != DC && resp_sync_success !== e.exp_sync[0])
			mismatch("resp_sync_success (table)", e.exp_sync[0], resp_sync_success);
		if (e.exp_reads != DC && reads_seen != e.exp_reads)
			mismatch("mem reads", e.exp_reads, reads_seen);
		if (e.exp_writes != DC && writes_seen != e.exp_writes)
			mismatch("mem writes", e.exp_writes, writes_seen);
		reads_seen = 0;
		writes_seen = 0;
	endtask

	initial
	begin
		error_count = 0;
		resp_count = 0;
		reads_seen = 0;
		writes_seen = 0;
		mem_req_q = 1'b0;
		for (int a = 0; a < (1 << ADDR_WIDTH); a++)
			lines[a] = line_init(ADDR_WIDTH'(a));
		for (int l = 0; l < NUM_LINKS; l++)
		begin
			link_valid[l] = 1'b0;
			link_address[l] = '0;
		end
	end

	// Values seen at the edge are the ones from before it
	always @(posedge clk)
	begin
		if (!reset)
		begin
			if (mem_req && !mem_req_q)
			begin
				if (mem_ack)
					fault("memory request raised while acknowledge still high");
				if (mem_write)
					writes_seen++;
				else
					reads_seen++;
			end
			if (resp_valid)
				check_response();
			if (l2req_valid && !stall)
				model_request();
		end
		mem_req_q = mem_req;
	end

endmodule

// ==== bench/l2_cache_tb.sv ====
`timescale 1ns/1ns
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// L2 cache testbench
// Clock, reset, stimulus table, memory model and watchdog
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module l2_cache_tb import l2_cache_pkg::*; ();
	localparam int CYCLE = 10;
	localparam int NUM_CORES = 4;
	localparam int NUM_STRANDS = 4;
	localparam int SET_INDEX_WIDTH = 3;
	localparam int NUM_RANDOM = 48;
	// Writeback plus fill with slowest memory, in cycles
	localparam int MISS_BOUND = 80;
	localparam logic [1:0] DC = 2'd2;

	typedef struct packed {
		logic [1:0] core;
		logic [1:0] strand;
		l2_op_t op;
		logic [ADDR_WIDTH-1:0] address;
		logic [LINE_BITS-1:0] data;
		logic [LINE_BYTES-1:0] mask;
		logic [3:0] gap;
		logic [1:0] exp_sync;
		logic [1:0] exp_reads;
		logic [1:0] exp_writes;
	} row_t;

	logic clk;
	logic reset;
	logic l2req_valid;
	logic [$clog2(NUM_CORES)-1:0] l2req_core;
	logic [$clog2(NUM_STRANDS)-1:0] l2req_strand;
	l2_op_t l2req_op;
	logic [ADDR_WIDTH-1:0] l2req_address;
	logic [LINE_BITS-1:0] l2req_data;
	logic [LINE_BYTES-1:0] l2req_mask;
	logic stall;
	logic resp_valid;
	logic [$clog2(NUM_CORES)-1:0] resp_core;
	logic [$clog2(NUM_STRANDS)-1:0] resp_strand;
	l2_op_t resp_op;
	logic [LINE_BITS-1:0] resp_data;
	logic resp_sync_success;
	logic mem_req;
	logic mem_write;
	logic [ADDR_WIDTH-1:0] mem_address;
	logic [LINE_BITS-1:0] mem_write_data;
	logic mem_ack;
	logic [LINE_BITS-1:0] mem_read_data;
	// Row expectations handed to the checker with the request
	logic [1:0] exp_sync;
	logic [1:0] exp_reads;
	logic [1:0] exp_writes;
	int error_count;
	int resp_count;

	row_t rows[$];
	logic table_ready = 1'b0;
	logic [15:0] lfsr = 16'd53;
	logic [LINE_BITS-1:0] mem_lines [1 << ADDR_WIDTH];

	`include "line_pattern.svh"

	l2_cache #(
		.NUM_CORES(NUM_CORES),
		.NUM_STRANDS(NUM_STRANDS),
		.SET_INDEX_WIDTH(SET_INDEX_WIDTH)
	) dut_i (.*);

	l2_cache_checker #(
		.NUM_CORES(NUM_CORES),
		.NUM_STRANDS(NUM_STRANDS)
	) checker_i (.*);

	// Galois LFSR, one step per bit taken
	function automatic logic [LINE_BITS-1:0] take_bits(input int n);
		logic [LINE_BITS-1:0] value;
		value = '0;
		for (int i = 0; i < n; i++)
		begin
			value[i] = lfsr[0];
			lfsr = (lfsr >> 1) ^ (lfsr[0] ? 16'hB400 : 16'h0000);
		end
		return value;
	endfunction

	task automatic add_row(input logic [1:0] core, input logic [1:0] strand, input l2_op_t op,
		input logic [ADDR_WIDTH-1:0] address, input logic [LINE_BITS-1:0] data,
		input logic [LINE_BYTES-1:0] mask, input logic [3:0] gap,
		input logic [1:0] es, input logic [1:0] er, input logic [1:0] ew);
		row_t r;
		r = {core, strand, op, address, data, mask, gap, es, er, ew};
		rows.push_back(r);
	endtask

	task automatic build_table();
		logic [2:0] set;
		logic sel;
		// Load miss, then a hit that needs no memory
		add_row(0, 0, LOAD, 12'h011, '0, '0, 0, DC, 1, 0);
		add_row(0, 0, LOAD, 12'h011, '0, '0, 2, DC, 0, 0);
		// Partial store and load, back-to-back then with gaps
		add_row(1, 0, STORE, 12'h011, {4{32'hA1B2_C3D4}}, 16'h00F0, 0, 0, 0, 0);
		add_row(1, 1, LOAD, 12'h011, '0, '0, 0, DC, 0, 0);
		add_row(2, 0, STORE, 12'h022, {4{32'h5566_7788}}, 16'hF00F, 3, 0, 1, 0);
		add_row(2, 1, LOAD, 12'h022, '0, '0, 3, DC, 0, 0);
		// Sync pair that succeeds
		add_row(3, 2, LOAD_SYNC, 12'h033, '0, '0, 0, 0, 1, 0);
		add_row(3, 2, STORE_SYNC, 12'h033, {4{32'hCAFE_0033}}, 16'hFFFF, 0, 1, 0, 0);
		add_row(3, 2, LOAD, 12'h033, '0, '0, 2, 0, 0, 0);
		// Another core's store breaks the link
		add_row(0, 1, LOAD_SYNC, 12'h033, '0, '0, 0, 0, 0, 0);
		add_row(2, 3, STORE, 12'h033, {4{32'h2233_4455}}, 16'h0F0F, 0, 0, 0, 0);
		add_row(0, 1, STORE_SYNC, 12'h033, {4{32'hDEAD_BEEF}}, 16'hFFFF, 0, 0, 0, 0);
		add_row(1, 2, LOAD, 12'h033, '0, '0, 2, 0, 0, 0);
		// Three lines in set 5, dirty victims go back to memory
		add_row(0, 0, STORE, 12'h105, {4{32'h0105_F00D}}, 16'hFFFF, 0, 0, 1, 0);
		add_row(1, 0, STORE, 12'h205, {4{32'h0205_BEAD}}, 16'hFFFF, 0, 0, 1, 0);
		add_row(2, 0, LOAD, 12'h305, '0, '0, 2, 0, 1, 1);
		add_row(3, 0, LOAD, 12'h105, '0, '0, 0, 0, 1, 1);
		add_row(3, 1, LOAD, 12'h205, '0, '0, 3, 0, 1, 0);
		// Random mix, two tags per set against the lines above
		for (int i = 0; i < NUM_RANDOM; i++)
		begin
			set = take_bits(3);
			sel = take_bits(1);
			add_row(take_bits(2), take_bits(2), l2_op_t'(take_bits(2)),
				{sel ? 9'h0A6 : 9'h153, set}, take_bits(LINE_BITS), take_bits(LINE_BYTES),
				0, DC, DC, DC);
		end
	endtask

	// Present one row and hold it until taken
	task automatic apply_row(input row_t r);
		logic held;
		#1;
		l2req_valid = 1'b1;
		l2req_core = r.core;
		l2req_strand = r.strand;
		l2req_op = r.op;
		l2req_address = r.address;
		l2req_data = r.data;
		l2req_mask = r.mask;
		exp_sync = r.exp_sync;
		exp_reads = r.exp_reads;
		exp_writes = r.exp_writes;
		// Stall only moves at rising edges, read it mid-cycle
		do
		begin
			@(negedge clk);
			held = stall;
			@(posedge clk);
		end
		while (held);
		if (r.gap != 0)
		begin
			#1 l2req_valid = 1'b0;
			repeat (r.gap) @(posedge clk);
		end
	endtask

	initial
	begin
		clk = 1'b0;
		forever
			#(CYCLE / 2) clk = ~clk;
	end

	// Behavioral memory with random four-phase handshake delays
	initial
	begin
		int delay;
		mem_ack = 1'b0;
		mem_read_data = '0;
		for (int a = 0; a < (1 << ADDR_WIDTH); a++)
			mem_lines[a] = line_init(ADDR_WIDTH'(a));
		forever
		begin
			@(negedge clk);
			if (mem_req)
			begin
				delay = take_bits(2);
				repeat (delay) @(posedge clk);
				@(posedge clk);
				#1;
				if (mem_write)
					mem_lines[mem_address] = mem_write_data;
				else
					mem_read_data = mem_lines[mem_address];
				mem_ack = 1'b1;
				// Wait for the request to drop
				do
					@(negedge clk);
				while (mem_req);
				delay = take_bits(2);
				repeat (delay) @(posedge clk);
				@(posedge clk);
				#1 mem_ack = 1'b0;
			end
		end
	end

	initial
	begin
		reset = 1'b1;
		l2req_valid = 1'b0;
		l2req_core = '0;
		l2req_strand = '0;
		l2req_op = LOAD;
		l2req_address = '0;
		l2req_data = '0;
		l2req_mask = '0;
		exp_sync = DC;
		exp_reads = DC;
		exp_writes = DC;
		build_table();
		table_ready = 1'b1;
		repeat (8) @(posedge clk);
		#1 reset = 1'b0;
		@(posedge clk);
		foreach (rows[i])
			apply_row(rows[i]);
		#1 l2req_valid = 1'b0;
		wait (resp_count == rows.size());
		// Catch any stray response after the last one
		repeat (4) @(posedge clk);
		$display("Responses %0d of %0d, errors %0d", resp_count, rows.size(), error_count);
		if (error_count == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

	// Watchdog scaled by the table length
	initial
	begin
		wait (table_ready);
		#((rows.size() * MISS_BOUND + 40) * CYCLE);
		$display("Timeout: not all responses arrived before the time limit");
		$display("Responses %0d of %0d, errors %0d", resp_count, rows.size(), error_count);
		$display(">>> FAIL");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+bench
hw/l2_cache_pkg.sv
hw/l2_cache_tag.sv
hw/l2_cache_read.sv
hw/l2_cache_write.sv
hw/l2_cache_smi.sv
hw/l2_cache.sv
bench/l2_cache_checker.sv
bench/l2_cache_tb.sv

// ==== Bender.yml ====
package:
  name: l2_cache

sources:
  - hw/l2_cache_pkg.sv
  - hw/l2_cache_tag.sv
  - hw/l2_cache_read.sv
  - hw/l2_cache_write.sv
  - hw/l2_cache_smi.sv
  - hw/l2_cache.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/l2_cache_checker.sv
      - bench/l2_cache_tb.sv
